/* hdl/sort_pkg.sv */
/*
 * Bitonic sorter shared definitions
 * Key width, key and stage counts, and the key vector and stage
 * index types used by the sequencer, network and key register.
 */
package sort_pkg;

    // Key geometry
    localparam int KEY_W     = 8;
    localparam int NUM_KEYS  = 32;
    localparam int NUM_PAIRS = NUM_KEYS / 2;

    // 1 + 2 + 3 + 4 + 5 stages for 32 keys
    localparam int NUM_STAGES = 15;
    localparam int STAGE_W    = 4;

    // One unsigned key
    typedef logic [KEY_W-1:0] key_t;

    // Index 0 is the lowest position
    typedef key_t [NUM_KEYS-1:0] key_vec_t;

    // Network stage index
    typedef logic [STAGE_W-1:0] stage_t;

    localparam stage_t LAST_STAGE = stage_t'(NUM_STAGES - 1);

endpackage

/* hdl/sort_sequencer.sv */
/*
 * Bitonic sorter sequencer
 * Turns the load strobe into a load pulse for the key register, a
 * step level with the current network stage for 15 cycles, and a
 * one-cycle done pulse after the last stage. A new strobe restarts
 * the count from stage 0 at any time.
 */
`timescale 1ns/1ps

module sort_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              vld_in,
    output logic              load,
    output logic              step,
    output sort_pkg::stage_t  stage,
    output logic              vld_out
);

    import sort_pkg::*;

    logic   busy;
    stage_t stage_cnt;
    logic   last_step;
    logic   done_q;

    assign last_step = busy && (stage_cnt == LAST_STAGE);

    // Stage counter, busy low means idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            stage_cnt <= '0;
        end else if (vld_in) begin
            busy      <= 1'b1;
            stage_cnt <= '0;
        end else if (busy) begin
            if (stage_cnt == LAST_STAGE) begin
                busy <= 1'b0;
            end else begin
                stage_cnt <= stage_cnt + 1'b1;
            end
        end
    end

    // A strobe on the last step cancels the pending result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= last_step && !vld_in;
        end
    end

    // Load takes the cycle, step stays off while loading
    assign load    = vld_in;
    assign step    = busy && !vld_in;
    assign stage   = stage_cnt;
    assign vld_out = done_q;

endmodule

/* hdl/bitonic_stage_network.sv */
/*
 * Bitonic stage network
 * One bank of 16 compare-exchange units. The stage index selects
 * the merge block size and the partner distance; each unit pairs a
 * position with the one that differs only in the distance bit and
 * orders the pair by the block-size bit of its lower index.
 * Purely combinational.
 */
`timescale 1ns/1ps

module bitonic_stage_network (
    input  sort_pkg::stage_t    stage,
    input  sort_pkg::key_vec_t  keys_in,
    output sort_pkg::key_vec_t  keys_out
);

    import sort_pkg::*;

    // One spare bit so the block-size bit of a 32 block reads as clear
    typedef logic [$clog2(NUM_KEYS):0] idx_t;

    logic [2:0] blk_lg;
    logic [2:0] dist_lg;

    idx_t lo_idx [NUM_PAIRS];
    idx_t hi_idx [NUM_PAIRS];
    key_t lo_key [NUM_PAIRS];
    key_t hi_key [NUM_PAIRS];

    // Lower index of pair p: insert a zero at the distance bit
    function automatic idx_t pair_low(input int unsigned p, input logic [2:0] d);
        idx_t pos;
        idx_t mask;
        pos  = idx_t'(p);
        mask = (idx_t'(1) << d) - idx_t'(1);
        return ((pos & ~mask) << 1) | (pos & mask);
    endfunction

    // log2 of block size and partner distance per stage
    always_comb begin
        case (stage)
            4'd0:    begin blk_lg = 3'd1; dist_lg = 3'd0; end
            4'd1:    begin blk_lg = 3'd2; dist_lg = 3'd1; end
            4'd2:    begin blk_lg = 3'd2; dist_lg = 3'd0; end
            4'd3:    begin blk_lg = 3'd3; dist_lg = 3'd2; end
            4'd4:    begin blk_lg = 3'd3; dist_lg = 3'd1; end
            4'd5:    begin blk_lg = 3'd3; dist_lg = 3'd0; end
            4'd6:    begin blk_lg = 3'd4; dist_lg = 3'd3; end
            4'd7:    begin blk_lg = 3'd4; dist_lg = 3'd2; end
            4'd8:    begin blk_lg = 3'd4; dist_lg = 3'd1; end
            4'd9:    begin blk_lg = 3'd4; dist_lg = 3'd0; end
            4'd10:   begin blk_lg = 3'd5; dist_lg = 3'd4; end
            4'd11:   begin blk_lg = 3'd5; dist_lg = 3'd3; end
            4'd12:   begin blk_lg = 3'd5; dist_lg = 3'd2; end
            4'd13:   begin blk_lg = 3'd5; dist_lg = 3'd1; end
            default: begin blk_lg = 3'd5; dist_lg = 3'd0; end
        endcase
    end

    for (genvar p = 0; p < NUM_PAIRS; p++) begin : g_cmp
        key_t a;
        key_t b;
        logic desc;
        logic swap;

        always_comb begin
            lo_idx[p] = pair_low(p, dist_lg);
            hi_idx[p] = lo_idx[p] | (idx_t'(1) << dist_lg);
            a         = keys_in[lo_idx[p][$clog2(NUM_KEYS)-1:0]];
            b         = keys_in[hi_idx[p][$clog2(NUM_KEYS)-1:0]];
            desc      = lo_idx[p][blk_lg];
            // Ascending puts the smaller key low, descending the larger
            swap      = desc ? (a < b) : (a > b);
            lo_key[p] = swap ? b : a;
            hi_key[p] = swap ? a : b;
        end
    end

    // Each position is written by exactly one unit
    always_comb begin
        keys_out = keys_in;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            keys_out[lo_idx[p][$clog2(NUM_KEYS)-1:0]] = lo_key[p];
            keys_out[hi_idx[p][$clog2(NUM_KEYS)-1:0]] = hi_key[p];
        end
    end

endmodule

/* hdl/sort_key_register.sv */
/*
 * Sort key register
 * Holds the 32 keys in position order. Captures the input vector
 * on load, the network result on step, and holds otherwise, so the
 * sorted keys stay visible until the next load.
 */
`timescale 1ns/1ps

module sort_key_register (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load,
    input  logic                step,
    input  sort_pkg::key_vec_t  din,
    input  sort_pkg::key_vec_t  next_keys,
    output sort_pkg::key_vec_t  keys
);

    import sort_pkg::*;

    key_vec_t keys_q;

    // Load wins over step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keys_q <= '0;
        end else if (load) begin
            keys_q <= din;
        end else if (step) begin
            keys_q <= next_keys;
        end
    end

    assign keys = keys_q;

endmodule

/* hdl/bitonic_sorter.sv */
/*
 * Iterative bitonic sorter, 32 unsigned 8-bit keys
 * A load strobe captures all keys; one bank of compare-exchange
 * units is reused over 15 stages, and the ascending result is held
 * on dout with a one-cycle vld_out pulse when the last stage is done.
 */
`timescale 1ns/1ps

module bitonic_sorter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                vld_in,
    input  sort_pkg::key_vec_t  din,
    output logic                vld_out,
    output sort_pkg::key_vec_t  dout
);

    import sort_pkg::*;

    logic     load;
    logic     step;
    stage_t   stage;
    key_vec_t keys;
    key_vec_t next_keys;

    sort_sequencer sort_sequencer_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .vld_in  (vld_in),
        .load    (load),
        .step    (step),
        .stage   (stage),
        .vld_out (vld_out)
    );

    bitonic_stage_network bitonic_stage_network_inst (
        .stage    (stage),
        .keys_in  (keys),
        .keys_out (next_keys)
    );

    // Register output is both the result and the network input
    sort_key_register sort_key_register_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .step      (step),
        .din       (din),
        .next_keys (next_keys),
        .keys      (keys)
    );

    assign dout = keys;

endmodule

/* dv/bitonic_sorter_checker.sv */
/*
 * Bitonic sorter protocol checker
 * Bound to the sorter top level. Watches the done pulse width and
 * latency, and the order of the keys shown with the pulse.
 */
`timescale 1ns/1ps

module bitonic_sorter_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                vld_in,
    input logic                vld_out,
    input sort_pkg::key_vec_t  dout
);

    import sort_pkg::*;

    logic       seen_load;
    logic [4:0] since_load;
    logic       dout_ordered;

    // Cycles since the last sampled strobe, saturating
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_load  <= 1'b0;
            since_load <= '1;
        end else if (vld_in) begin
            seen_load  <= 1'b1;
            since_load <= '0;
        end else if (since_load != '1) begin
            since_load <= since_load + 5'd1;
        end
    end

    always_comb begin
        dout_ordered = 1'b1;
        for (int i = 1; i < NUM_KEYS; i++) begin
            if (dout[i] < dout[i-1]) begin
                dout_ordered = 1'b0;
            end
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        vld_out |=> !vld_out)
        else $error("vld_out high on two consecutive cycles");

    // 15 quiet cycles after a strobe, and only then
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        vld_out == (seen_load && since_load == 5'd15))
        else $error("vld_out not exactly 15 cycles after the last vld_in");

    a_sorted: assert property (@(posedge clk) disable iff (!rst_n)
        vld_out |-> dout_ordered)
        else $error("dout not in ascending order with vld_out");

    a_no_early_done: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_load |-> !vld_out)
        else $error("vld_out raised before any vld_in");

endmodule

bind bitonic_sorter bitonic_sorter_checker bitonic_sorter_checker_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld_in  (vld_in),
    .vld_out (vld_out),
    .dout    (dout)
);

/* dv/bitonic_sorter_tb.sv */
/*
 * Testbench for the iterative bitonic sorter
 * Drives random and corner key vectors, a hold period, a restart and
 * a back-to-back load, and compares every result with a reference sort.
 */
`timescale 1ns/1ps

module bitonic_sorter_tb;

    import sort_pkg::*;

    localparam int          CLK_PERIOD     = 8;
    localparam int          DRIVE_DELAY    = 1;
    localparam int          RESET_CYCLES   = 3;
    localparam int          SORT_LATENCY   = 15;
    localparam int          NUM_RANDOM     = 60;
    localparam int          NUM_CORNERS    = 5;
    localparam int          HOLD_CYCLES    = 10;
    localparam int          DONE_LIMIT     = 40;
    localparam int          TIMEOUT_CYCLES = 3000;
    localparam logic [15:0] LFSR_SEED      = 16'd64171;
    localparam logic [15:0] LFSR_TAPS      = 16'hB400;

    logic     clk;
    logic     rst_n;
    logic     vld_in;
    key_vec_t din;
    logic     vld_out;
    key_vec_t dout;

    int          cycle_cnt;
    int          check_cnt;
    int          result_cnt;
    int          mismatch_cnt;
    int          other_err_cnt;
    logic [15:0] lfsr_state;

    // Results still due, oldest first
    key_vec_t exp_vec_q[$];
    int       exp_cyc_q[$];

    bitonic_sorter bitonic_sorter_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .vld_in  (vld_in),
        .din     (din),
        .vld_out (vld_out),
        .dout    (dout)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    always @(posedge clk) begin
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // One LFSR step per key bit
    task automatic random_vector(output key_vec_t v);
        key_t k;
        for (int i = 0; i < NUM_KEYS; i++) begin
            k = '0;
            for (int b = 0; b < KEY_W; b++) begin
                k = {k[KEY_W-2:0], lfsr_state[0]};
                lfsr_state = lfsr_next(lfsr_state);
            end
            v[i] = k;
        end
    endtask

    // Reference result by insertion sort, smallest key at index 0
    function automatic key_vec_t sorted_copy(input key_vec_t v);
        key_t     a [NUM_KEYS];
        key_t     t;
        int       j;
        key_vec_t r;
        for (int i = 0; i < NUM_KEYS; i++) begin
            a[i] = v[i];
        end
        for (int i = 1; i < NUM_KEYS; i++) begin
            t = a[i];
            j = i;
            while (j > 0 && a[j-1] > t) begin
                a[j] = a[j-1];
                j--;
            end
            a[j] = t;
        end
        for (int i = 0; i < NUM_KEYS; i++) begin
            r[i] = a[i];
        end
        return r;
    endfunction

    function automatic key_vec_t corner_pattern(input int id);
        key_vec_t v;
        for (int i = 0; i < NUM_KEYS; i++) begin
            case (id)
                0:       v[i] = 8'h5A;
                1:       v[i] = key_t'(i * 8);
                2:       v[i] = key_t'(255 - i * 8);
                3:       v[i] = (i % 2 == 0) ? 8'h00 : 8'hFF;
                default: v[i] = (i == 13) ? 8'hFF : 8'h00;
            endcase
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic compare_keys(input key_vec_t exp_v);
        for (int i = 0; i < NUM_KEYS; i++) begin
            check_cnt++;
            assert (dout[i] == exp_v[i]) else begin
                mismatch_cnt++;
                $display("Mismatch at %0t: dout[%0d] got %0d, expected %0d",
                         $realtime, i, dout[i], exp_v[i]);
            end
        end
    endtask

    // A result still due at or after the new E0 is cancelled by it
    task automatic load_vector(input key_vec_t v);
        int e0;
        e0 = cycle_cnt + 1;
        while (exp_cyc_q.size() > 0 && exp_cyc_q[$] >= e0) begin
            void'(exp_cyc_q.pop_back());
            void'(exp_vec_q.pop_back());
        end
        exp_vec_q.push_back(sorted_copy(v));
        exp_cyc_q.push_back(e0 + SORT_LATENCY);
        din    = v;
        vld_in = 1'b1;
        next_cycle();
        vld_in = 1'b0;
    endtask

    // Returns in the cycle where vld_out is high
    task automatic wait_for_done();
        int n;
        n = 0;
        while (!vld_out && n < DONE_LIMIT) begin
            next_cycle();
            n++;
        end
        check_cnt++;
        assert (vld_out) else begin
            other_err_cnt++;
            $display("Error at %0t: vld_out not seen within %0d cycles of a load",
                     $realtime, DONE_LIMIT);
        end
    endtask

    task automatic run_sort(input key_vec_t v);
        load_vector(v);
        wait_for_done();
    endtask

    // Compare process, sampled mid-cycle
    task automatic check_output_cycle();
        logic missing;
        missing = exp_cyc_q.size() > 0 && exp_cyc_q[0] < cycle_cnt;
        check_cnt++;
        assert (!missing) else begin
            other_err_cnt++;
            $display("Error at %0t: vld_out missing, it was due in cycle %0d",
                     $realtime, exp_cyc_q[0]);
        end
        if (missing) begin
            void'(exp_cyc_q.pop_front());
            void'(exp_vec_q.pop_front());
        end
        if (vld_out) begin
            check_cnt++;
            assert (exp_cyc_q.size() > 0 && exp_cyc_q[0] == cycle_cnt) else begin
                other_err_cnt++;
                $display("Error at %0t: vld_out in cycle %0d with no result due then",
                         $realtime, cycle_cnt);
            end
            if (exp_cyc_q.size() > 0 && exp_cyc_q[0] == cycle_cnt) begin
                compare_keys(exp_vec_q[0]);
                void'(exp_cyc_q.pop_front());
                void'(exp_vec_q.pop_front());
                result_cnt++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check_output_cycle();
        end
    end

    initial begin
        key_vec_t v;
        key_vec_t v2;
        key_vec_t held;
        int       base;
        $timeformat(-9, 1, " ns", 0);
        cycle_cnt     = 0;
        check_cnt     = 0;
        result_cnt    = 0;
        mismatch_cnt  = 0;
        other_err_cnt = 0;
        lfsr_state    = LFSR_SEED;
        rst_n         = 1'b0;
        vld_in        = 1'b0;
        din           = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // Reset state until the first load
        repeat (4) begin
            next_cycle();
            check_cnt++;
            assert (!vld_out) else begin
                other_err_cnt++;
                $display("Error at %0t: vld_out high after reset without a load", $realtime);
            end
            compare_keys('0);
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_vector(v);
            run_sort(v);
            idle(i % 4);
        end

        for (int id = 0; id < NUM_CORNERS; id++) begin
            run_sort(corner_pattern(id));
            idle(1);
        end

        // Hold after done
        random_vector(v);
        run_sort(v);
        held = sorted_copy(v);
        repeat (HOLD_CYCLES) begin
            next_cycle();
            check_cnt++;
            assert (!vld_out) else begin
                other_err_cnt++;
                $display("Error at %0t: second vld_out while holding a result", $realtime);
            end
            compare_keys(held);
        end

        // Restart 6 cycles into a sort
        random_vector(v);
        random_vector(v2);
        base = result_cnt;
        load_vector(v);
        idle(5);
        load_vector(v2);
        wait_for_done();
        idle(6);
        check_cnt++;
        assert (result_cnt == base + 1) else begin
            other_err_cnt++;
            $display("Error: restart gave %0d results instead of one", result_cnt - base);
        end

        // New load in the vld_out cycle
        random_vector(v);
        random_vector(v2);
        base = result_cnt;
        run_sort(v);
        run_sort(v2);
        idle(3);
        check_cnt++;
        assert (result_cnt == base + 2) else begin
            other_err_cnt++;
            $display("Error: back-to-back loads gave %0d results instead of two",
                     result_cnt - base);
        end

        check_cnt++;
        assert (exp_cyc_q.size() == 0) else begin
            other_err_cnt++;
            $display("Error: %0d results never arrived", exp_cyc_q.size());
        end

        $display("Checks: %0d, results: %0d, mismatches: %0d, other errors: %0d",
                 check_cnt, result_cnt, mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/sort_pkg.sv
hdl/sort_sequencer.sv
hdl/bitonic_stage_network.sv
hdl/sort_key_register.sv
hdl/bitonic_sorter.sv
dv/bitonic_sorter_checker.sv
dv/bitonic_sorter_tb.sv

/* Makefile */
# Verilator build and run of the bitonic sorter testbench

VERILATOR ?= verilator
TOP       ?= bitonic_sorter_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
PASS_LINE := '\*\*\* PASSED \*\*\*'

.PHONY: all run check clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx $(PASS_LINE) $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

check:
	@test -f $(LOG) || (echo "No $(LOG) found, run the simulation first"; exit 1)
	@grep -qx $(PASS_LINE) $(LOG) && echo "$(LOG) reports a pass" || \
		(echo "$(LOG) reports no pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
